// ==== hdl/es_pkg.sv ====
/* shared widths, GTX receive DRP register map and engine state encodings
   7-series GTX only, the GTH field layout is not covered */

package es_pkg;

  // ***********************************************************************
  // widths and types

  localparam int DRP_ADDR_W = 12;
  localparam int DRP_DATA_W = 16;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;

  typedef logic [DRP_ADDR_W-1:0] drp_addr_t;
  typedef logic [DRP_DATA_W-1:0] drp_data_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;

  typedef logic [11:0] hofs_t;
  // vertical index is two's complement, converted to sign-magnitude on write
  typedef logic [7:0]  vofs_t;
  typedef logic [4:0]  pscale_t;
  typedef logic [1:0]  vrange_t;

  // ***********************************************************************
  // GTX eye-scan registers

  localparam drp_addr_t ES_DRP_CTRL_ADDR    = 12'h03d;
  localparam drp_addr_t ES_DRP_HOFFSET_ADDR = 12'h03c;
  localparam drp_addr_t ES_DRP_VOFFSET_ADDR = 12'h03b;
  localparam drp_addr_t ES_DRP_STATUS_ADDR  = 12'h151;
  localparam drp_addr_t ES_DRP_SCNT_ADDR    = 12'h150;
  localparam drp_addr_t ES_DRP_ECNT_ADDR    = 12'h14f;

  localparam logic [3:0] ES_STATUS_DONE   = 4'b0101;
  localparam axi_addr_t  ES_RESULT_STRIDE = 32'd4;

  // request states are odd, each wait-for-ready state sits right after it
  typedef enum logic [4:0] {
    ES_DRP_IDLE       = 5'h00,
    ES_DRP_HOFS_RD    = 5'h01,
    ES_DRP_HOFS_RRDY  = 5'h02,
    ES_DRP_HOFS_WR    = 5'h03,
    ES_DRP_HOFS_WRDY  = 5'h04,
    ES_DRP_VOFS_RD    = 5'h05,
    ES_DRP_VOFS_RRDY  = 5'h06,
    ES_DRP_VOFS_WR    = 5'h07,
    ES_DRP_VOFS_WRDY  = 5'h08,
    ES_DRP_CTRL_RD    = 5'h09,
    ES_DRP_CTRL_RRDY  = 5'h0a,
    ES_DRP_START_WR   = 5'h0b,
    ES_DRP_START_WRDY = 5'h0c,
    ES_DRP_STAT_RD    = 5'h0d,
    ES_DRP_STAT_RRDY  = 5'h0e,
    ES_DRP_STOP_WR    = 5'h0f,
    ES_DRP_STOP_WRDY  = 5'h10,
    ES_DRP_SCNT_RD    = 5'h11,
    ES_DRP_SCNT_RRDY  = 5'h12,
    ES_DRP_ECNT_RD    = 5'h13,
    ES_DRP_ECNT_RRDY  = 5'h14
  } es_drp_state_t;

  typedef enum logic [1:0] {
    ES_CTRL_IDLE,
    ES_CTRL_MEASURE,
    ES_CTRL_STORE,
    ES_CTRL_UPDATE
  } es_ctrl_state_t;

endpackage

// ==== hdl/es_sweep.sv ====
/* offset grid walker, one step per advance pulse
   hindex moves only when ut is high, so DFE scans visit each point twice */

module es_sweep (
  input  logic              up_clk,
  input  logic              up_rstn,
  input  logic              load,
  input  logic              advance,
  input  logic              up_ch_lpm_dfe_n,
  input  es_pkg::hofs_t     up_es_hmin,
  input  es_pkg::hofs_t     up_es_hmax,
  input  es_pkg::hofs_t     up_es_hstep,
  input  es_pkg::vofs_t     up_es_vmin,
  input  es_pkg::vofs_t     up_es_vmax,
  input  es_pkg::vofs_t     up_es_vstep,
  input  es_pkg::axi_addr_t up_es_saddr,
  output es_pkg::hofs_t     hindex,
  output es_pkg::vofs_t     vindex,
  output logic              ut,
  output logic              heos,
  output logic              eos,
  output es_pkg::axi_addr_t daddr
);

  // end of row needs the second ut phase in DFE mode
  assign heos = (hindex == up_es_hmax) ? ut : 1'b0;
  assign eos = (vindex == up_es_vmax) ? heos : 1'b0;

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      ut <= 1'b0;
      hindex <= '0;
      vindex <= '0;
      daddr <= '0;
    end else if (load == 1'b1) begin
      // LPM holds ut high, DFE starts on the low phase
      ut <= up_ch_lpm_dfe_n;
      hindex <= up_es_hmin;
      vindex <= up_es_vmin;
      daddr <= up_es_saddr;
    end else if (advance == 1'b1) begin
      ut <= ~ut | up_ch_lpm_dfe_n;
      daddr <= daddr + es_pkg::ES_RESULT_STRIDE;
      if (heos == 1'b1) begin
        hindex <= up_es_hmin;
        // wraps in two's complement
        vindex <= vindex + up_es_vstep;
      end else if (ut == 1'b1) begin
        hindex <= hindex + up_es_hstep;
      end
    end
  end

endmodule

// ==== hdl/es_drp_seq.sv ====
/* DRP transaction sequence for one scan point, one access in flight at a time
   status is polled with no limit, a stuck transceiver stalls the scan here */

module es_drp_seq (
  input  logic              up_clk,
  input  logic              up_rstn,
  input  logic              point_start,
  input  logic              full_point,
  input  es_pkg::hofs_t     hindex,
  input  es_pkg::vofs_t     vindex,
  input  logic              ut,
  input  logic              up_ch_lpm_dfe_n,
  input  es_pkg::pscale_t   up_es_pscale,
  input  es_pkg::drp_data_t up_es_rdata,
  input  logic              up_es_ready,
  output logic              up_es_enb,
  output es_pkg::drp_addr_t up_es_addr,
  output logic              up_es_wr,
  output es_pkg::drp_data_t up_es_wdata,
  output logic              point_done,
  output es_pkg::drp_data_t sample_count,
  output es_pkg::drp_data_t error_count
);

  es_pkg::es_drp_state_t drp_state;
  es_pkg::drp_data_t     hdata;
  es_pkg::drp_data_t     vdata;
  es_pkg::drp_data_t     cdata;
  es_pkg::drp_addr_t     req_addr;
  es_pkg::drp_data_t     req_wdata;
  es_pkg::vofs_t         vindex_neg;
  es_pkg::vofs_t         vindex_sm;
  logic                  req_wr;
  logic                  drp_req;
  logic                  drp_busy;
  logic                  ut_s;
  logic                  status_done;

  assign drp_req = drp_state[0];
  assign status_done = (up_es_rdata[3:0] == es_pkg::ES_STATUS_DONE);

  // GTX wants the vertical offset in sign-magnitude
  assign ut_s = ut & ~up_ch_lpm_dfe_n;
  assign vindex_neg = ~vindex + 8'd1;
  assign vindex_sm = (vindex[7] == 1'b1) ? {1'b1, vindex_neg[6:0]} : vindex;

  // ***********************************************************************
  // state machine

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      drp_state <= es_pkg::ES_DRP_IDLE;
    end else begin
      case (drp_state)
        es_pkg::ES_DRP_IDLE: begin
          if (point_start == 1'b1) begin
            drp_state <= (full_point == 1'b1) ? es_pkg::ES_DRP_HOFS_RD :
                                                 es_pkg::ES_DRP_VOFS_RD;
          end
        end
        es_pkg::ES_DRP_STAT_RRDY: begin
          if (up_es_ready == 1'b1) begin
            drp_state <= (status_done == 1'b1) ? es_pkg::ES_DRP_STOP_WR :
                                                  es_pkg::ES_DRP_STAT_RD;
          end
        end
        es_pkg::ES_DRP_ECNT_RRDY: begin
          if (up_es_ready == 1'b1) begin
            drp_state <= es_pkg::ES_DRP_IDLE;
          end
        end
        default: begin
          // request states step once, wait states step on ready
          if ((drp_req == 1'b1) || (up_es_ready == 1'b1)) begin
            drp_state <= es_pkg::es_drp_state_t'(drp_state + 5'd1);
          end
        end
      endcase
    end
  end

  // ***********************************************************************
  // access decode

  always_comb begin
    req_addr = es_pkg::ES_DRP_CTRL_ADDR;
    req_wr = 1'b0;
    // run field cleared, as in the stop write
    req_wdata = {cdata[15:10], 2'b11, cdata[7:6], 6'd0};
    case (drp_state)
      es_pkg::ES_DRP_HOFS_RD: req_addr = es_pkg::ES_DRP_HOFFSET_ADDR;
      es_pkg::ES_DRP_HOFS_WR: begin
        req_addr = es_pkg::ES_DRP_HOFFSET_ADDR;
        req_wr = 1'b1;
        req_wdata = {hdata[15:12], hindex};
      end
      es_pkg::ES_DRP_VOFS_RD: req_addr = es_pkg::ES_DRP_VOFFSET_ADDR;
      es_pkg::ES_DRP_VOFS_WR: begin
        req_addr = es_pkg::ES_DRP_VOFFSET_ADDR;
        req_wr = 1'b1;
        req_wdata = {up_es_pscale, vdata[10:9], ut_s, vindex_sm};
      end
      es_pkg::ES_DRP_START_WR: begin
        req_wr = 1'b1;
        req_wdata = {cdata[15:10], 2'b11, cdata[7:6], 6'd1};
      end
      es_pkg::ES_DRP_STOP_WR: req_wr = 1'b1;
      es_pkg::ES_DRP_STAT_RD: req_addr = es_pkg::ES_DRP_STATUS_ADDR;
      es_pkg::ES_DRP_SCNT_RD: req_addr = es_pkg::ES_DRP_SCNT_ADDR;
      es_pkg::ES_DRP_ECNT_RD: req_addr = es_pkg::ES_DRP_ECNT_ADDR;
      default: ;
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      up_es_enb <= 1'b0;
      up_es_wr <= 1'b0;
      point_done <= 1'b0;
    end else begin
      up_es_enb <= drp_req;
      up_es_wr <= drp_req & req_wr;
      point_done <= (drp_state == es_pkg::ES_DRP_ECNT_RRDY) & up_es_ready;
    end
  end

  always_ff @(posedge up_clk) begin
    if (drp_req == 1'b1) begin
      up_es_addr <= req_addr;
      up_es_wdata <= req_wdata;
    end
  end

  // shadow copies for read-modify-write and the counters
  always_ff @(posedge up_clk) begin
    if (up_es_ready == 1'b1) begin
      case (drp_state)
        es_pkg::ES_DRP_HOFS_RRDY: hdata <= up_es_rdata;
        es_pkg::ES_DRP_VOFS_RRDY: vdata <= up_es_rdata;
        es_pkg::ES_DRP_CTRL_RRDY: cdata <= up_es_rdata;
        es_pkg::ES_DRP_SCNT_RRDY: sample_count <= up_es_rdata;
        es_pkg::ES_DRP_ECNT_RRDY: error_count <= up_es_rdata;
        default: ;
      endcase
    end
  end

  // ***********************************************************************
  // protocol checks

  // access outstanding from enb until its ready
  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      drp_busy <= 1'b0;
    end else if (up_es_enb == 1'b1) begin
      drp_busy <= 1'b1;
    end else if (up_es_ready == 1'b1) begin
      drp_busy <= 1'b0;
    end
  end

  a_enb_pulse: assert property (@(posedge up_clk) disable iff (up_rstn == 1'b0)
    up_es_enb |=> !up_es_enb);

  a_enb_wait: assert property (@(posedge up_clk) disable iff (up_rstn == 1'b0)
    drp_busy |-> !up_es_enb);

endmodule

// ==== hdl/es_axi_writer.sv ====
/* single-beat AXI write of one result word, bready is taken as always high
   responses that arrive with no write outstanding are ignored */

module es_axi_writer (
  input  logic              up_clk,
  input  logic              up_rstn,
  input  logic              store,
  input  es_pkg::axi_addr_t daddr,
  input  es_pkg::drp_data_t sample_count,
  input  es_pkg::drp_data_t error_count,
  input  logic              up_axi_awready,
  input  logic              up_axi_wready,
  input  logic              up_axi_bvalid,
  input  logic [1:0]        up_axi_bresp,
  output logic              up_axi_awvalid,
  output es_pkg::axi_addr_t up_axi_awaddr,
  output logic              up_axi_wvalid,
  output es_pkg::axi_data_t up_axi_wdata,
  output logic              stored,
  output logic              up_es_status
);

  logic busy;
  logic resp;

  assign resp = up_axi_bvalid & busy;

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      up_axi_awvalid <= 1'b0;
      up_axi_wvalid <= 1'b0;
      busy <= 1'b0;
      stored <= 1'b0;
      up_es_status <= 1'b0;
    end else begin
      // address and data channels complete independently
      if (store == 1'b1) begin
        up_axi_awvalid <= 1'b1;
      end else if (up_axi_awready == 1'b1) begin
        up_axi_awvalid <= 1'b0;
      end
      if (store == 1'b1) begin
        up_axi_wvalid <= 1'b1;
      end else if (up_axi_wready == 1'b1) begin
        up_axi_wvalid <= 1'b0;
      end
      if (store == 1'b1) begin
        busy <= 1'b1;
      end else if (resp == 1'b1) begin
        busy <= 1'b0;
      end
      stored <= resp;
      // slverr or decerr, held until the next response
      if (resp == 1'b1) begin
        up_es_status <= |up_axi_bresp;
      end
    end
  end

  always_ff @(posedge up_clk) begin
    if (store == 1'b1) begin
      up_axi_awaddr <= daddr;
      up_axi_wdata <= {sample_count, error_count};
    end
  end

  a_aw_hold: assert property (@(posedge up_clk) disable iff (up_rstn == 1'b0)
    (up_axi_awvalid && !up_axi_awready) |=> (up_axi_awvalid && $stable(up_axi_awaddr)));

endmodule

// ==== hdl/es_scan_ctrl.sv ====
/* point-by-point scan control, started by a rising edge of the request
   dropping the request ends the scan after the point in progress */

module es_scan_ctrl (
  input  logic up_clk,
  input  logic up_rstn,
  input  logic up_es_req,
  input  logic ut,
  input  logic eos,
  input  logic point_done,
  input  logic stored,
  output logic load,
  output logic advance,
  output logic point_start,
  output logic full_point,
  output logic store,
  output logic up_es_ack
);

  es_pkg::es_ctrl_state_t ctrl_state;
  logic                   req_d;
  logic                   start;
  logic                   scan_end;

  assign start = up_es_req & ~req_d;
  assign scan_end = eos | ~up_es_req;

  assign load = (ctrl_state == es_pkg::ES_CTRL_IDLE) & start;
  assign advance = (ctrl_state == es_pkg::ES_CTRL_UPDATE);
  assign point_start = load | (advance & ~scan_end);
  // horizontal rewrite only after the high ut phase, ut is still pre-advance here
  assign full_point = advance ? ut : 1'b1;
  assign store = (ctrl_state == es_pkg::ES_CTRL_MEASURE) & point_done;

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      ctrl_state <= es_pkg::ES_CTRL_IDLE;
      req_d <= 1'b0;
      up_es_ack <= 1'b0;
    end else begin
      req_d <= up_es_req;
      up_es_ack <= advance & scan_end;
      case (ctrl_state)
        es_pkg::ES_CTRL_IDLE: begin
          if (start == 1'b1) begin
            ctrl_state <= es_pkg::ES_CTRL_MEASURE;
          end
        end
        es_pkg::ES_CTRL_MEASURE: begin
          if (point_done == 1'b1) begin
            ctrl_state <= es_pkg::ES_CTRL_STORE;
          end
        end
        es_pkg::ES_CTRL_STORE: begin
          if (stored == 1'b1) begin
            ctrl_state <= es_pkg::ES_CTRL_UPDATE;
          end
        end
        default: begin
          ctrl_state <= (scan_end == 1'b1) ? es_pkg::ES_CTRL_IDLE :
                                              es_pkg::ES_CTRL_MEASURE;
        end
      endcase
    end
  end

endmodule

// ==== hdl/es_eye_scan.sv ====
/* eye-scan engine for a 7-series GTX receive channel, results at saddr + 4*n
   up_es_vrange is accepted for register compatibility, GTX has no field for it */

module es_eye_scan (
  input  logic              up_clk,
  input  logic              up_rstn,

  // DRP port
  output logic              up_es_enb,
  output es_pkg::drp_addr_t up_es_addr,
  output logic              up_es_wr,
  output es_pkg::drp_data_t up_es_wdata,
  input  es_pkg::drp_data_t up_es_rdata,
  input  logic              up_es_ready,

  // scan settings and handshake
  input  logic              up_ch_lpm_dfe_n,
  input  logic              up_es_req,
  output logic              up_es_ack,
  input  es_pkg::pscale_t   up_es_pscale,
  input  es_pkg::vrange_t   up_es_vrange,
  input  es_pkg::vofs_t     up_es_vstep,
  input  es_pkg::vofs_t     up_es_vmax,
  input  es_pkg::vofs_t     up_es_vmin,
  input  es_pkg::hofs_t     up_es_hmax,
  input  es_pkg::hofs_t     up_es_hmin,
  input  es_pkg::hofs_t     up_es_hstep,
  input  es_pkg::axi_addr_t up_es_saddr,
  output logic              up_es_status,

  // AXI write channel
  output logic              up_axi_awvalid,
  output es_pkg::axi_addr_t up_axi_awaddr,
  input  logic              up_axi_awready,
  output logic              up_axi_wvalid,
  output es_pkg::axi_data_t up_axi_wdata,
  input  logic              up_axi_wready,
  input  logic              up_axi_bvalid,
  input  logic [1:0]        up_axi_bresp
);

  es_pkg::hofs_t     hindex;
  es_pkg::vofs_t     vindex;
  es_pkg::axi_addr_t daddr;
  es_pkg::drp_data_t sample_count;
  es_pkg::drp_data_t error_count;
  logic              ut;
  logic              eos;
  logic              load;
  logic              advance;
  logic              point_start;
  logic              full_point;
  logic              point_done;
  logic              store;
  logic              stored;

  es_sweep i_sweep (
    .up_clk (up_clk), .up_rstn (up_rstn),
    .load (load), .advance (advance), .up_ch_lpm_dfe_n (up_ch_lpm_dfe_n),
    .up_es_hmin (up_es_hmin), .up_es_hmax (up_es_hmax), .up_es_hstep (up_es_hstep),
    .up_es_vmin (up_es_vmin), .up_es_vmax (up_es_vmax), .up_es_vstep (up_es_vstep),
    .up_es_saddr (up_es_saddr),
    .hindex (hindex), .vindex (vindex), .ut (ut),
    .heos (), .eos (eos), .daddr (daddr));

  es_drp_seq i_drp_seq (
    .up_clk (up_clk), .up_rstn (up_rstn),
    .point_start (point_start), .full_point (full_point),
    .hindex (hindex), .vindex (vindex), .ut (ut),
    .up_ch_lpm_dfe_n (up_ch_lpm_dfe_n), .up_es_pscale (up_es_pscale),
    .up_es_rdata (up_es_rdata), .up_es_ready (up_es_ready),
    .up_es_enb (up_es_enb), .up_es_addr (up_es_addr),
    .up_es_wr (up_es_wr), .up_es_wdata (up_es_wdata),
    .point_done (point_done),
    .sample_count (sample_count), .error_count (error_count));

  es_axi_writer i_axi_writer (
    .up_clk (up_clk), .up_rstn (up_rstn),
    .store (store), .daddr (daddr),
    .sample_count (sample_count), .error_count (error_count),
    .up_axi_awready (up_axi_awready), .up_axi_wready (up_axi_wready),
    .up_axi_bvalid (up_axi_bvalid), .up_axi_bresp (up_axi_bresp),
    .up_axi_awvalid (up_axi_awvalid), .up_axi_awaddr (up_axi_awaddr),
    .up_axi_wvalid (up_axi_wvalid), .up_axi_wdata (up_axi_wdata),
    .stored (stored), .up_es_status (up_es_status));

  es_scan_ctrl i_scan_ctrl (
    .up_clk (up_clk), .up_rstn (up_rstn),
    .up_es_req (up_es_req), .ut (ut), .eos (eos),
    .point_done (point_done), .stored (stored),
    .load (load), .advance (advance),
    .point_start (point_start), .full_point (full_point),
    .store (store), .up_es_ack (up_es_ack));

endmodule

// ==== testbench/tb_transceiver_model.sv ====
/* DRP register model and AXI write sink for the eye-scan testbench
   both take their random choices from the rnd word of the testbench */

module drp_responder (
  input  logic              up_clk,
  input  logic              up_rstn,
  input  logic [31:0]       rnd,
  input  logic              up_es_enb,
  input  es_pkg::drp_addr_t up_es_addr,
  input  logic              up_es_wr,
  input  es_pkg::drp_data_t up_es_wdata,
  output es_pkg::drp_data_t up_es_rdata,
  output logic              up_es_ready
);

  es_pkg::drp_data_t hreg;
  es_pkg::drp_data_t vreg;
  es_pkg::drp_data_t creg;
  es_pkg::drp_addr_t addr;
  es_pkg::drp_data_t wdata;
  logic              wr;
  int                polls;

  initial begin
    up_es_rdata = '0;
    up_es_ready = 1'b0;
    polls = 0;
    forever begin
      @(posedge up_clk);
      #1;
      up_es_ready = 1'b0;
      if (up_rstn == 1'b0) begin
        // random power-up contents
        hreg = rnd[15:0];
        vreg = rnd[31:16];
        creg = rnd[23:8];
      end else if (up_es_enb == 1'b1) begin
        addr = up_es_addr;
        wr = up_es_wr;
        wdata = up_es_wdata;
        // ready latency of 1 to 4 cycles
        repeat (int'(rnd[1:0]) + 1) @(posedge up_clk);
        #1;
        up_es_ready = 1'b1;
        up_es_rdata = rnd[31:16];
        if (wr == 1'b1) begin
          case (addr)
            es_pkg::ES_DRP_HOFFSET_ADDR: hreg = wdata;
            es_pkg::ES_DRP_VOFFSET_ADDR: vreg = wdata;
            es_pkg::ES_DRP_CTRL_ADDR: begin
              creg = wdata;
              // start write arms a new number of busy polls
              if (wdata[0] == 1'b1) begin
                polls = int'(rnd[6:4]);
              end
            end
            default: ;
          endcase
        end else begin
          case (addr)
            es_pkg::ES_DRP_HOFFSET_ADDR: up_es_rdata = hreg;
            es_pkg::ES_DRP_VOFFSET_ADDR: up_es_rdata = vreg;
            es_pkg::ES_DRP_CTRL_ADDR: up_es_rdata = creg;
            es_pkg::ES_DRP_STATUS_ADDR: begin
              if (polls > 0) begin
                polls = polls - 1;
                up_es_rdata = {rnd[27:16], 4'b0000};
              end else begin
                up_es_rdata = {rnd[27:16], 4'b0101};
              end
            end
            // counters return fresh random values
            default: ;
          endcase
        end
      end
    end
  end

endmodule

module axi_sink (
  input  logic        up_clk,
  input  logic [31:0] rnd,
  input  logic        up_axi_awvalid,
  input  logic        up_axi_wvalid,
  output logic        up_axi_awready,
  output logic        up_axi_wready,
  output logic        up_axi_bvalid,
  output logic [1:0]  up_axi_bresp
);

  logic got_aw;
  logic got_w;
  logic fire;

  initial begin
    up_axi_awready = 1'b0;
    up_axi_wready = 1'b0;
    up_axi_bvalid = 1'b0;
    up_axi_bresp = 2'b00;
    got_aw = 1'b0;
    got_w = 1'b0;
    fire = 1'b0;
    forever begin
      @(negedge up_clk);
      got_aw = got_aw | (up_axi_awvalid & up_axi_awready);
      got_w = got_w | (up_axi_wvalid & up_axi_wready);
      fire = got_aw & got_w;
      @(posedge up_clk);
      #1;
      up_axi_bvalid = fire;
      // slverr on about one write in four
      up_axi_bresp = (fire && (rnd[9:8] == 2'b00)) ? 2'b10 : 2'b00;
      up_axi_awready = rnd[10];
      up_axi_wready = rnd[11];
      if (fire == 1'b1) begin
        got_aw = 1'b0;
        got_w = 1'b0;
      end
    end
  end

endmodule

// ==== testbench/tb_eye_scan.sv ====
/* eye-scan testbench, random grids in LPM and DFE mode against a reference sweep
   the last scan drops the request mid-scan */

module tb_eye_scan;

  localparam int NUM_SCANS = 6;
  localparam int MAX_POINTS = 4 * 3 * 2;
  localparam int POINT_CYCLES = 400;
  localparam int WATCHDOG_TIME = NUM_SCANS * MAX_POINTS * POINT_CYCLES * 10 + 2000;
  localparam logic [31:0] SEED = 32'h78fa_6001;

  logic              up_clk = 1'b0;
  logic              up_rstn;
  logic [31:0]       rnd;
  logic [31:0]       cfg;
  logic              up_es_enb;
  es_pkg::drp_addr_t up_es_addr;
  logic              up_es_wr;
  es_pkg::drp_data_t up_es_wdata;
  es_pkg::drp_data_t up_es_rdata;
  logic              up_es_ready;
  logic              up_ch_lpm_dfe_n;
  logic              up_es_req;
  logic              up_es_ack;
  es_pkg::pscale_t   up_es_pscale;
  es_pkg::vrange_t   up_es_vrange;
  es_pkg::vofs_t     up_es_vstep;
  es_pkg::vofs_t     up_es_vmax;
  es_pkg::vofs_t     up_es_vmin;
  es_pkg::hofs_t     up_es_hmax;
  es_pkg::hofs_t     up_es_hmin;
  es_pkg::hofs_t     up_es_hstep;
  es_pkg::axi_addr_t up_es_saddr;
  logic              up_es_status;
  logic              up_axi_awvalid;
  es_pkg::axi_addr_t up_axi_awaddr;
  logic              up_axi_awready;
  logic              up_axi_wvalid;
  es_pkg::axi_data_t up_axi_wdata;
  logic              up_axi_wready;
  logic              up_axi_bvalid;
  logic [1:0]        up_axi_bresp;

  // reference sweep and captured transceiver values
  es_pkg::hofs_t     ref_h;
  es_pkg::vofs_t     ref_v;
  logic              ref_ut;
  logic              ref_full;
  logic              heos;
  int                ref_n;
  es_pkg::axi_addr_t ref_addr;
  es_pkg::drp_data_t h_rd;
  es_pkg::drp_data_t v_rd;
  es_pkg::drp_data_t c_rd;
  es_pkg::drp_data_t scnt;
  es_pkg::drp_data_t ecnt;
  es_pkg::drp_addr_t cur_addr;
  logic              cur_wr;
  logic              started;
  logic              done_seen;
  logic              hwrite_seen;
  es_pkg::axi_addr_t aw_addr;
  es_pkg::axi_data_t w_data;
  logic              exp_status;
  logic              status_due;
  logic              scan_active;

  always #5 up_clk = ~up_clk;

  es_eye_scan dut_i (.*);

  drp_responder xcvr_i (
    .up_clk (up_clk), .up_rstn (up_rstn), .rnd (rnd),
    .up_es_enb (up_es_enb), .up_es_addr (up_es_addr), .up_es_wr (up_es_wr),
    .up_es_wdata (up_es_wdata), .up_es_rdata (up_es_rdata), .up_es_ready (up_es_ready));

  axi_sink mem_i (
    .up_clk (up_clk), .rnd (rnd),
    .up_axi_awvalid (up_axi_awvalid), .up_axi_wvalid (up_axi_wvalid),
    .up_axi_awready (up_axi_awready), .up_axi_wready (up_axi_wready),
    .up_axi_bvalid (up_axi_bvalid), .up_axi_bresp (up_axi_bresp));

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic es_pkg::vofs_t sign_mag(input es_pkg::vofs_t v);
    es_pkg::vofs_t mag;
    mag = v[7] ? (8'd0 - v) : v;
    return {v[7], mag[6:0]};
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  // ************************************************************************
  // compare tasks

  task automatic check_drp_write(input es_pkg::drp_addr_t addr, input es_pkg::drp_data_t got,
                                 input es_pkg::drp_data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error at %0t: up_es_wdata @ %h = %h, expected %h",
                               $time, addr, got, exp));
    end
  endtask

  task automatic check_result(input es_pkg::axi_addr_t got_a, input es_pkg::axi_data_t got_d,
                              input es_pkg::axi_addr_t exp_a, input es_pkg::axi_data_t exp_d);
    if (got_a !== exp_a) begin
      report_failure($sformatf("** Error at %0t: up_axi_awaddr = %h, expected %h",
                               $time, got_a, exp_a));
    end
    if (got_d !== exp_d) begin
      report_failure($sformatf("** Error at %0t: up_axi_wdata = %h, expected %h",
                               $time, got_d, exp_d));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  // ************************************************************************
  // monitors sampled on the falling edge

  task automatic check_drp_access();
    case (up_es_addr)
      es_pkg::ES_DRP_HOFFSET_ADDR: begin
        check_drp_write(up_es_addr, up_es_wdata, {h_rd[15:12], ref_h});
        hwrite_seen = 1'b1;
      end
      es_pkg::ES_DRP_VOFFSET_ADDR: begin
        // horizontal rewrite only on a full point
        check_bit("horizontal rewrite", hwrite_seen, ref_full);
        check_drp_write(up_es_addr, up_es_wdata,
                        {up_es_pscale, v_rd[10:9], ref_ut & ~up_ch_lpm_dfe_n, sign_mag(ref_v)});
      end
      es_pkg::ES_DRP_CTRL_ADDR: begin
        if (started == 1'b0) begin
          check_drp_write(up_es_addr, up_es_wdata, {c_rd[15:10], 2'b11, c_rd[7:6], 6'd1});
          started = 1'b1;
          done_seen = 1'b0;
        end else begin
          if (done_seen == 1'b0) begin
            report_failure("stop write issued before the status showed done");
          end
          check_drp_write(up_es_addr, up_es_wdata, {c_rd[15:10], 2'b11, c_rd[7:6], 6'd0});
        end
      end
      default: report_failure("DRP write to an unexpected address");
    endcase
  endtask

  task automatic capture_read();
    case (cur_addr)
      es_pkg::ES_DRP_HOFFSET_ADDR: h_rd = up_es_rdata;
      es_pkg::ES_DRP_VOFFSET_ADDR: v_rd = up_es_rdata;
      es_pkg::ES_DRP_CTRL_ADDR: c_rd = up_es_rdata;
      es_pkg::ES_DRP_STATUS_ADDR: done_seen = (up_es_rdata[3:0] == 4'b0101);
      es_pkg::ES_DRP_SCNT_ADDR: scnt = up_es_rdata;
      es_pkg::ES_DRP_ECNT_ADDR: ecnt = up_es_rdata;
      default: ;
    endcase
  endtask

  task automatic store_result();
    check_result(aw_addr, w_data, ref_addr, {scnt, ecnt});
    exp_status = |up_axi_bresp;
    status_due = 1'b1;
    ref_n = ref_n + 1;
    ref_addr = ref_addr + 32'd4;
    started = 1'b0;
    hwrite_seen = 1'b0;
    // hindex moves on the high ut phase only
    heos = (ref_h == up_es_hmax) && ref_ut;
    ref_full = ref_ut;
    if (heos == 1'b1) begin
      ref_h = up_es_hmin;
      ref_v = ref_v + up_es_vstep;
    end else if (ref_ut == 1'b1) begin
      ref_h = ref_h + up_es_hstep;
    end
    ref_ut = ~ref_ut | up_ch_lpm_dfe_n;
  endtask

  always @(negedge up_clk) begin
    rnd = xorshift(rnd);
    if (up_rstn == 1'b1) begin
      if (status_due == 1'b1) begin
        check_bit("up_es_status", up_es_status, exp_status);
      end
      status_due = 1'b0;
      if (up_es_ack == 1'b1) begin
        if (scan_active == 1'b0) begin
          report_failure("ack pulsed with no scan in progress");
        end
        scan_active = 1'b0;
      end
      if (up_es_enb == 1'b1) begin
        cur_addr = up_es_addr;
        cur_wr = up_es_wr;
        if (up_es_wr == 1'b1) begin
          check_drp_access();
        end
      end
      if ((up_es_ready == 1'b1) && (cur_wr == 1'b0)) begin
        capture_read();
      end
      if ((up_axi_awvalid & up_axi_awready) == 1'b1) begin
        aw_addr = up_axi_awaddr;
      end
      if ((up_axi_wvalid & up_axi_wready) == 1'b1) begin
        w_data = up_axi_wdata;
      end
      if (up_axi_bvalid == 1'b1) begin
        store_result();
      end
    end
  end

  // ************************************************************************
  // stimulus

  task automatic run_scan(input logic cut);
    int hcount;
    int vcount;
    int points;
    cfg = xorshift(cfg);
    @(posedge up_clk);
    #1;
    up_ch_lpm_dfe_n = cfg[0];
    up_es_hstep = es_pkg::hofs_t'(cfg[2:1]) + 12'd1;
    hcount = cut ? 4 : int'(cfg[4:3]) + 1;
    up_es_hmin = es_pkg::hofs_t'(cfg[12:5]);
    up_es_hmax = up_es_hmin + up_es_hstep * es_pkg::hofs_t'(hcount - 1);
    up_es_vstep = es_pkg::vofs_t'(cfg[14:13]) + 8'd1;
    vcount = (cfg[16:15] == 2'b11) ? 1 : int'(cfg[16:15]) + 1;
    up_es_vmin = es_pkg::vofs_t'(cfg[21:17]) - 8'd16;
    up_es_vmax = up_es_vmin + up_es_vstep * es_pkg::vofs_t'(vcount - 1);
    up_es_pscale = cfg[26:22];
    up_es_vrange = cfg[28:27];
    cfg = xorshift(cfg);
    up_es_saddr = {cfg[31:2], 2'b00};
    points = hcount * vcount * (up_ch_lpm_dfe_n ? 1 : 2);
    ref_h = up_es_hmin;
    ref_v = up_es_vmin;
    ref_ut = up_ch_lpm_dfe_n;
    ref_full = 1'b1;
    ref_n = 0;
    ref_addr = up_es_saddr;
    started = 1'b0;
    hwrite_seen = 1'b0;
    scan_active = 1'b1;
    up_es_req = 1'b1;
    if (cut == 1'b1) begin
      while (ref_n < 2) @(posedge up_clk);
      #1;
      up_es_req = 1'b0;
    end
    while (scan_active == 1'b1) @(posedge up_clk);
    if ((cut == 1'b0) && (ref_n != points)) begin
      report_failure($sformatf("scan ended after %0d result writes, expected %0d",
                               ref_n, points));
    end
    if ((cut == 1'b1) && (ref_n >= points)) begin
      report_failure("scan did not stop after the request dropped");
    end
    #1;
    up_es_req = 1'b0;
    repeat (4) @(posedge up_clk);
  endtask

  initial begin
    up_rstn = 1'b0;
    rnd = xorshift(SEED);
    cfg = SEED;
    up_ch_lpm_dfe_n = 1'b1;
    up_es_req = 1'b0;
    up_es_pscale = '0;
    up_es_vrange = '0;
    up_es_vstep = 8'd1;
    up_es_vmax = '0;
    up_es_vmin = '0;
    up_es_hmax = '0;
    up_es_hmin = '0;
    up_es_hstep = 12'd1;
    up_es_saddr = '0;
    cur_addr = '0;
    cur_wr = 1'b0;
    status_due = 1'b0;
    scan_active = 1'b0;
    repeat (2) @(posedge up_clk);
    #1;
    up_rstn = 1'b1;
    for (int scan = 0; scan < NUM_SCANS; scan++) begin
      run_scan(scan == NUM_SCANS - 1);
    end
    $display("Test completed successfully");
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    report_failure("watchdog expired before all scans finished");
  end

endmodule

// ==== tb.f ====
hdl/es_pkg.sv
hdl/es_sweep.sv
hdl/es_drp_seq.sv
hdl/es_axi_writer.sv
hdl/es_scan_ctrl.sv
hdl/es_eye_scan.sv
testbench/tb_transceiver_model.sv
testbench/tb_eye_scan.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the eye-scan testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_eye_scan \
  -Mdir obj_dir -o sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && exit 1 || grep -q "Test completed successfully" sim.log || exit 1
